// ==== src/core_pkg.sv ====
// Shared definitions for the multi-cycle RV32I core
// Widths, sequencer states, ALU operations, opcodes and instruction formats
package core_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // PC increment per instruction
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // --------------------
    // Sequencer states
    typedef enum logic [1:0]
    {
        ST_RESET    = 2'd0,
        ST_FETCH_WB = 2'd1,
        ST_EXEC     = 2'd2,
        ST_MEM      = 2'd3
    } state_t;

    // --------------------
    // ALU operations, NONE passes operand a
    typedef enum logic [3:0]
    {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLL  = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_AND  = 4'd10
    } alu_op_t;

    // --------------------
    // Major opcodes, instruction bits 6:2
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_OPIMM  = 5'b00100;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_JAL    = 5'b11011;

    // --------------------
    // One instruction word, four views
    typedef struct packed
    {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed
    {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed
    {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed
    {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed
    {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } inst_t;

endpackage

// ==== src/exec_if.sv ====
// Decoded execute controls, from the decoder to the sequencer
// All fields are combinational and follow the current instruction word
`timescale 1ns/10ps

interface exec_if
    import core_pkg::*;
();

    // ALU operation and operands
    alu_op_t                alu_op;
    logic [XLEN-1:0]        alu_a;
    logic [XLEN-1:0]        alu_b;

    // Writeback target
    logic                   write_rd;
    logic [REG_IDX_W-1:0]   rd;

    // Memory access kind
    logic                   is_load;
    logic                   is_store;

    // Control flow
    logic                   take_branch;
    logic [XLEN-1:0]        branch_target;

    // Data request, address not yet aligned
    logic [XLEN-1:0]        mem_addr;
    logic [XLEN-1:0]        mem_wdata;

    modport dec
    (
        output alu_op, alu_a, alu_b, write_rd, rd, is_load, is_store,
        output take_branch, branch_target, mem_addr, mem_wdata
    );

    modport seq
    (
        input alu_op, alu_a, alu_b, write_rd, rd, is_load, is_store,
        input take_branch, branch_target, mem_addr, mem_wdata
    );

endinterface

// ==== src/core_alu.sv ====
// Integer ALU
// Ten RV32I operations on the registered operands, purely combinational
`timescale 1ns/10ps

module core_alu
    import core_pkg::*;
(
    input  alu_op_t         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o
);

    // Shift amount from low bits of b
    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb
    begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            // Sign bit replicated into the vacated bits
            ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            // Compares return 0 or 1
            ALU_SLT:  result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: result_o = {31'd0, a_i < b_i};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            // NONE and anything unknown pass a through
            default:  result_o = a_i;
        endcase
    end

endmodule

// ==== src/core_regfile.sv ====
// Register file, 32 x 32 bits
// Two combinational read ports, one write port, x0 reads as zero
`timescale 1ns/10ps

module core_regfile
    import core_pkg::*;
(
    input  logic                 clk_i,
    input  inst_t                inst_i,
    input  logic                 wr_en_i,
    input  logic [REG_IDX_W-1:0] wr_idx_i,
    input  logic [XLEN-1:0]      wr_data_i,
    output logic [XLEN-1:0]      rs1_val_o,
    output logic [XLEN-1:0]      rs2_val_o
);

    logic [XLEN-1:0] regs [32];

    // Write lands at the next edge
    always_ff @(posedge clk_i)
    begin
        if (wr_en_i)
            regs[wr_idx_i] <= wr_data_i;
    end

    // Source indexes sit at the same bits in every format
    // Entry 0 is never written, so force zero on read
    assign rs1_val_o = (inst_i.r_fmt.rs1 == '0) ? '0 : regs[inst_i.r_fmt.rs1];
    assign rs2_val_o = (inst_i.r_fmt.rs2 == '0) ? '0 : regs[inst_i.r_fmt.rs2];

endmodule

// ==== src/core_decode.sv ====
// Instruction decoder
// Opcode class, immediates, ALU operands, branch compare and memory request
`timescale 1ns/10ps

module core_decode
    import core_pkg::*;
(
    input  inst_t           inst_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_val_i,
    input  logic [XLEN-1:0] rs2_val_i,
    exec_if.dec             ex
);

    logic [4:0]      opc;
    logic [2:0]      funct3;
    logic [6:0]      funct7;

    // Opcode classes
    logic type_load, type_opimm, type_auipc, type_store, type_op;
    logic type_lui, type_branch, type_jalr, type_jal;
    logic type_alu_op;

    // Immediates per format
    logic [XLEN-1:0] imm_i, imm_s, imm_u, imm_b, imm_j;

    logic            branch_cond;
    logic [XLEN-1:0] jalr_sum;

    // --------------------
    // Classify
    assign opc    = inst_i.r_fmt.opcode[6:2];
    assign funct3 = inst_i.r_fmt.funct3;
    assign funct7 = inst_i.r_fmt.funct7;

    assign type_load   = (opc == OPC_LOAD);
    assign type_opimm  = (opc == OPC_OPIMM);
    assign type_auipc  = (opc == OPC_AUIPC);
    assign type_store  = (opc == OPC_STORE);
    assign type_op     = (opc == OPC_OP);
    assign type_lui    = (opc == OPC_LUI);
    assign type_branch = (opc == OPC_BRANCH);
    assign type_jalr   = (opc == OPC_JALR);
    assign type_jal    = (opc == OPC_JAL);

    // Only base ALU encodings, others act as no-ops
    assign type_alu_op = type_op && ((funct7 == 7'b0000000) || (funct7 == 7'b0100000));

    // --------------------
    // Immediates
    assign imm_i = {{20{inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.imm12};
    assign imm_s = {{20{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
    assign imm_u = {inst_i.u_fmt.imm20, 12'd0};

    // B format reuses the S fields, bit 7 moves up to imm[11]
    assign imm_b = {{19{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi[6],
                    inst_i.s_fmt.imm_lo[0], inst_i.s_fmt.imm_hi[5:0],
                    inst_i.s_fmt.imm_lo[4:1], 1'b0};

    // J format scrambles the U field
    assign imm_j = {{11{inst_i.u_fmt.imm20[19]}}, inst_i.u_fmt.imm20[19],
                    inst_i.u_fmt.imm20[7:0], inst_i.u_fmt.imm20[8],
                    inst_i.u_fmt.imm20[18:9], 1'b0};

    // --------------------
    // ALU operand table
    always_comb
    begin
        ex.alu_op = ALU_NONE;
        ex.alu_a  = rs1_val_i;
        ex.alu_b  = rs2_val_i;

        if (type_alu_op || type_opimm)
        begin
            // Immediate form takes b from imm12
            if (type_opimm)
                ex.alu_b = imm_i;

            case (funct3)
                // Bit 30 selects SUB only for register form
                3'b000:  ex.alu_op = (type_op && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  ex.alu_op = ALU_SLL;
                3'b010:  ex.alu_op = ALU_SLT;
                3'b011:  ex.alu_op = ALU_SLTU;
                3'b100:  ex.alu_op = ALU_XOR;
                3'b101:  ex.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  ex.alu_op = ALU_OR;
                default: ex.alu_op = ALU_AND;
            endcase
        end
        else if (type_lui)
        begin
            ex.alu_op = ALU_ADD;
            ex.alu_a  = '0;
            ex.alu_b  = imm_u;
        end
        else if (type_auipc)
        begin
            ex.alu_op = ALU_ADD;
            ex.alu_a  = pc_i;
            ex.alu_b  = imm_u;
        end
        else if (type_jal || type_jalr)
        begin
            // Return address
            ex.alu_op = ALU_ADD;
            ex.alu_a  = pc_i;
            ex.alu_b  = PC_STEP;
        end
    end

    // Word accesses only
    assign ex.is_load  = type_load && (funct3 == 3'b010);
    assign ex.is_store = type_store && (funct3 == 3'b010);

    // Load data replaces the ALU result later
    assign ex.rd       = inst_i.r_fmt.rd;
    assign ex.write_rd = (type_alu_op || type_opimm || type_lui || type_auipc
                          || type_jal || type_jalr || ex.is_load)
                         && (inst_i.r_fmt.rd != '0);

    // --------------------
    // Branch compare
    always_comb
    begin
        case (funct3)
            3'b000:  branch_cond = (rs1_val_i == rs2_val_i);
            3'b001:  branch_cond = (rs1_val_i != rs2_val_i);
            3'b100:  branch_cond = ($signed(rs1_val_i) < $signed(rs2_val_i));
            3'b101:  branch_cond = ($signed(rs1_val_i) >= $signed(rs2_val_i));
            3'b110:  branch_cond = (rs1_val_i < rs2_val_i);
            3'b111:  branch_cond = (rs1_val_i >= rs2_val_i);
            default: branch_cond = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_val_i + imm_i;

    assign ex.take_branch = (type_branch && branch_cond) || type_jal || type_jalr;

    // JALR clears bit 0 of the sum
    always_comb
    begin
        if (type_jalr)
            ex.branch_target = {jalr_sum[XLEN-1:1], 1'b0};
        else if (type_jal)
            ex.branch_target = pc_i + imm_j;
        else
            ex.branch_target = pc_i + imm_b;
    end

    // --------------------
    // Load/store address and store data
    assign ex.mem_addr  = rs1_val_i + (type_store ? imm_s : imm_i);
    assign ex.mem_wdata = rs2_val_i;

endmodule

// ==== src/core_sequencer.sv ====
// Core sequencer
// Four-state FSM, PC, registered ALU inputs, writeback and data requests
`timescale 1ns/10ps

module core_sequencer
    import core_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [XLEN-1:0]      reset_vector_i,
    input  logic                 inst_valid_i,
    input  logic                 inst_accept_i,
    input  logic                 mem_d_accept_i,
    input  logic                 mem_d_ack_i,
    input  logic [XLEN-1:0]      mem_d_data_rd_i,
    exec_if.seq                  ex,
    output logic                 fetch_o,
    output logic [XLEN-1:0]      pc_o,
    output logic                 rf_wr_en_o,
    output logic [REG_IDX_W-1:0] rf_wr_idx_o,
    output logic [XLEN-1:0]      rf_wr_data_o,
    output logic [XLEN-1:0]      mem_d_addr_o,
    output logic [XLEN-1:0]      mem_d_data_wr_o,
    output logic                 mem_d_rd_o,
    output logic [3:0]           mem_d_wr_o
);

    state_t               state_q;
    state_t               state_d;
    logic [XLEN-1:0]      pc_q;

    // Registered ALU inputs
    alu_op_t              alu_op_q;
    logic [XLEN-1:0]      alu_a_q;
    logic [XLEN-1:0]      alu_b_q;

    // Pending writeback
    logic [REG_IDX_W-1:0] rd_q;
    logic                 rd_wr_en_q;

    // Data request
    logic [XLEN-1:0]      mem_addr_q;
    logic [XLEN-1:0]      mem_data_q;
    logic                 mem_rd_q;
    logic [3:0]           mem_wr_q;

    logic                 exec_fire;
    logic                 load_done;

    // Instruction word arrives in execute
    assign exec_fire = (state_q == ST_EXEC) && inst_valid_i;
    assign load_done = (state_q == ST_MEM) && mem_d_ack_i;

    // --------------------
    // Next state
    always_comb
    begin
        state_d = state_q;

        case (state_q)
            ST_RESET:
                state_d = ST_FETCH_WB;
            ST_FETCH_WB:
            begin
                if (inst_accept_i)
                    state_d = ST_EXEC;
            end
            ST_EXEC:
            begin
                if (inst_valid_i)
                    state_d = (ex.is_load || ex.is_store) ? ST_MEM : ST_FETCH_WB;
            end
            default:
            begin
                // Wait for the data access to finish
                if (mem_d_ack_i)
                    state_d = ST_FETCH_WB;
            end
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= ST_RESET;
        else
            state_q <= state_d;
    end

    // --------------------
    // PC update
    always_ff @(posedge clk_i)
    begin
        if (rst_i || (state_q == ST_RESET))
            pc_q <= reset_vector_i;
        else if (exec_fire)
            pc_q <= ex.take_branch ? ex.branch_target : pc_q + PC_STEP;
    end

    assign fetch_o = (state_q == ST_FETCH_WB);
    assign pc_o    = pc_q;

    // --------------------
    // ALU control and writeback enable
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            alu_op_q   <= ALU_NONE;
            rd_wr_en_q <= 1'b0;
        end
        else if (load_done)
            alu_op_q   <= ALU_NONE;
        else if (exec_fire)
        begin
            alu_op_q   <= ex.alu_op;
            rd_wr_en_q <= ex.write_rd;
        end
        // Write only in the first fetch cycle
        else if (state_q == ST_FETCH_WB)
            rd_wr_en_q <= 1'b0;
    end

    // Operands and destination
    always_ff @(posedge clk_i)
    begin
        if (load_done)
            alu_a_q <= mem_d_data_rd_i;
        else if (exec_fire)
        begin
            alu_a_q <= ex.alu_a;
            alu_b_q <= ex.alu_b;
            rd_q    <= ex.rd;
        end
    end

    core_alu u_alu
    (
        .op_i     (alu_op_q),
        .a_i      (alu_a_q),
        .b_i      (alu_b_q),
        .result_o (rf_wr_data_o)
    );

    assign rf_wr_en_o  = rd_wr_en_q && (state_q == ST_FETCH_WB);
    assign rf_wr_idx_o = rd_q;

    // --------------------
    // Data request, held until accepted
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mem_rd_q <= 1'b0;
            mem_wr_q <= 4'b0000;
        end
        else if (exec_fire)
        begin
            mem_rd_q <= ex.is_load;
            mem_wr_q <= {4{ex.is_store}};
        end
        else if (mem_d_accept_i)
        begin
            mem_rd_q <= 1'b0;
            mem_wr_q <= 4'b0000;
        end
    end

    // Word aligned address and store data
    always_ff @(posedge clk_i)
    begin
        if (exec_fire)
        begin
            mem_addr_q <= {ex.mem_addr[XLEN-1:2], 2'b00};
            mem_data_q <= ex.mem_wdata;
        end
    end

    assign mem_d_addr_o    = mem_addr_q;
    assign mem_d_data_wr_o = mem_data_q;
    assign mem_d_rd_o      = mem_rd_q;
    assign mem_d_wr_o      = mem_wr_q;

endmodule

// ==== src/uriscv_core.sv ====
// Multi-cycle RV32I core, top level
// Connects decoder, register file and sequencer to the memory ports
`timescale 1ns/10ps

module uriscv_core
    import core_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic [XLEN-1:0] reset_vector_i,

    // Instruction fetch
    output logic            mem_i_rd_o,
    output logic [XLEN-1:0] mem_i_pc_o,
    input  logic            mem_i_accept_i,
    input  logic            mem_i_valid_i,
    input  logic [XLEN-1:0] mem_i_inst_i,

    // Data access
    output logic [XLEN-1:0] mem_d_addr_o,
    output logic [XLEN-1:0] mem_d_data_wr_o,
    output logic            mem_d_rd_o,
    output logic [3:0]      mem_d_wr_o,
    input  logic [XLEN-1:0] mem_d_data_rd_i,
    input  logic            mem_d_accept_i,
    input  logic            mem_d_ack_i
);

    logic [XLEN-1:0]      pc_w;
    logic [XLEN-1:0]      rs1_val_w;
    logic [XLEN-1:0]      rs2_val_w;
    logic                 rf_wr_en_w;
    logic [REG_IDX_W-1:0] rf_wr_idx_w;
    logic [XLEN-1:0]      rf_wr_data_w;

    // Decoded controls for the current word
    exec_if ex_bus ();

    core_regfile u_regfile
    (
        .clk_i     (clk_i),
        .inst_i    (mem_i_inst_i),
        .wr_en_i   (rf_wr_en_w),
        .wr_idx_i  (rf_wr_idx_w),
        .wr_data_i (rf_wr_data_w),
        .rs1_val_o (rs1_val_w),
        .rs2_val_o (rs2_val_w)
    );

    core_decode u_decode
    (
        .inst_i    (mem_i_inst_i),
        .pc_i      (pc_w),
        .rs1_val_i (rs1_val_w),
        .rs2_val_i (rs2_val_w),
        .ex        (ex_bus.dec)
    );

    // Fetch request and PC come from the sequencer
    core_sequencer u_sequencer
    (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .reset_vector_i  (reset_vector_i),
        .inst_valid_i    (mem_i_valid_i),
        .inst_accept_i   (mem_i_accept_i),
        .mem_d_accept_i  (mem_d_accept_i),
        .mem_d_ack_i     (mem_d_ack_i),
        .mem_d_data_rd_i (mem_d_data_rd_i),
        .ex              (ex_bus.seq),
        .fetch_o         (mem_i_rd_o),
        .pc_o            (pc_w),
        .rf_wr_en_o      (rf_wr_en_w),
        .rf_wr_idx_o     (rf_wr_idx_w),
        .rf_wr_data_o    (rf_wr_data_w),
        .mem_d_addr_o    (mem_d_addr_o),
        .mem_d_data_wr_o (mem_d_data_wr_o),
        .mem_d_rd_o      (mem_d_rd_o),
        .mem_d_wr_o      (mem_d_wr_o)
    );

    assign mem_i_pc_o = pc_w;

endmodule

// ==== verification/tb_clock.sv ====
// Testbench clock source
// Free running clock, 40 ns period
`timescale 1ns/10ps

module tb_clock
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
    end

    // Half period
    always #20 clk_o = ~clk_o;

endmodule

// ==== verification/tb_checker.sv ====
// Store checker
// Compares every accepted data write with the next expected store
`timescale 1ns/10ps

module tb_checker
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [31:0] mem_d_addr_i,
    input  logic [31:0] mem_d_data_wr_i,
    input  logic [3:0]  mem_d_wr_i,
    input  logic        mem_d_accept_i,
    input  logic [31:0] exp_addr_i [64],
    input  logic [31:0] exp_data_i [64],
    input  int          exp_count_i,
    output int          seen_count_o,
    output int          pass_count_o,
    output int          fail_count_o
);

    initial
    begin
        seen_count_o = 0;
        pass_count_o = 0;
        fail_count_o = 0;
    end

    // Write is taken on the edge where accept meets the strobes
    // Word stores drive all four byte strobes
    always @(posedge clk_i)
    begin
        if (!rst_i && (mem_d_wr_i != 4'b0000) && mem_d_accept_i)
        begin
            if (seen_count_o >= exp_count_i)
            begin
                $display("Unexpected store to address %h with data %h after all %0d stores",
                         mem_d_addr_i, mem_d_data_wr_i, exp_count_i);
                fail_count_o <= fail_count_o + 1;
            end
            else if ((mem_d_addr_i == exp_addr_i[seen_count_o])
                     && (mem_d_data_wr_i == exp_data_i[seen_count_o])
                     && (mem_d_wr_i == 4'b1111))
            begin
                $display("Store %0d: addr %h data %h ok",
                         seen_count_o, mem_d_addr_i, mem_d_data_wr_i);
                pass_count_o <= pass_count_o + 1;
            end
            else
            begin
                // Pairs shown as addr/data
                $display("[ERROR] %0t ns: store %0d got %h/%h wr %b, expected %h/%h",
                         $time, seen_count_o, mem_d_addr_i, mem_d_data_wr_i, mem_d_wr_i,
                         exp_addr_i[seen_count_o], exp_data_i[seen_count_o]);
                fail_count_o <= fail_count_o + 1;
            end
            seen_count_o <= seen_count_o + 1;
        end
    end

endmodule

// ==== verification/tb_assert.sv ====
// Bus rule assertions on the core ports
// Bound into the core top level from the testbench
`timescale 1ns/10ps

module core_assert
(
    input logic        clk_i,
    input logic        rst_i,
    input logic        mem_i_rd_o,
    input logic [31:0] mem_d_addr_o,
    input logic        mem_d_rd_o,
    input logic [3:0]  mem_d_wr_o
);

    // Failed assertions, read by the testbench top
    int assert_fails = 0;

    // No read and write at once
    a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_d_rd_o && (mem_d_wr_o != 4'b0000)))
        else
        begin
            $error("data read and write strobes active together");
            assert_fails++;
        end

    // Word aligned data address
    a_addr_align: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_d_rd_o || (mem_d_wr_o != 4'b0000)) |-> (mem_d_addr_o[1:0] == 2'b00))
        else
        begin
            $error("data address not word aligned");
            assert_fails++;
        end

    // No fetch while a data request is pending
    a_no_fetch: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_d_rd_o || (mem_d_wr_o != 4'b0000)) |-> !mem_i_rd_o)
        else
        begin
            $error("fetch raised during a data request");
            assert_fails++;
        end

endmodule

// ==== verification/tb_top.sv ====
// Testbench top for the RV32I core
// Memory models with random wait states, cases file loading and final result
`timescale 1ns/10ps

module tb_top;

    logic        clk;
    logic        rst = 1'b1;
    logic [31:0] reset_vector = 32'h0000_0000;

    logic        mem_i_rd;
    logic [31:0] mem_i_pc;
    logic        mem_i_accept = 1'b0;
    logic        mem_i_valid = 1'b0;
    logic [31:0] mem_i_inst = 32'h0000_0013;

    logic [31:0] mem_d_addr;
    logic [31:0] mem_d_data_wr;
    logic        mem_d_rd;
    logic [3:0]  mem_d_wr;
    logic [31:0] mem_d_data_rd = 32'h0;
    logic        mem_d_accept = 1'b0;
    logic        mem_d_ack = 1'b0;

    // Cases file image and memories
    logic [31:0] case_words [512];
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    int          prog_len;
    int          exp_count;
    int          cycle_limit;
    int          cycles = 0;
    int          seen_count;
    int          pass_count;
    int          fail_count;
    logic        timed_out;

    // Memory model state
    int          i_phase = 0;
    int          i_wait = 0;
    logic [31:0] fetch_pc = 32'h0;
    int          d_phase = 0;
    int          d_wait = 0;
    logic [7:0]  d_idx = 8'h0;
    logic        d_is_wr = 1'b0;
    logic [31:0] d_wdata = 32'h0;
    logic [31:0] d_rdata = 32'h0;

    tb_clock u_clock
    (
        .clk_o (clk)
    );

    uriscv_core u_uriscv_core
    (
        .clk_i           (clk),
        .rst_i           (rst),
        .reset_vector_i  (reset_vector),
        .mem_i_rd_o      (mem_i_rd),
        .mem_i_pc_o      (mem_i_pc),
        .mem_i_accept_i  (mem_i_accept),
        .mem_i_valid_i   (mem_i_valid),
        .mem_i_inst_i    (mem_i_inst),
        .mem_d_addr_o    (mem_d_addr),
        .mem_d_data_wr_o (mem_d_data_wr),
        .mem_d_rd_o      (mem_d_rd),
        .mem_d_wr_o      (mem_d_wr),
        .mem_d_data_rd_i (mem_d_data_rd),
        .mem_d_accept_i  (mem_d_accept),
        .mem_d_ack_i     (mem_d_ack)
    );

    bind uriscv_core core_assert u_core_assert
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem_i_rd_o   (mem_i_rd_o),
        .mem_d_addr_o (mem_d_addr_o),
        .mem_d_rd_o   (mem_d_rd_o),
        .mem_d_wr_o   (mem_d_wr_o)
    );

    tb_checker u_checker
    (
        .clk_i           (clk),
        .rst_i           (rst),
        .mem_d_addr_i    (mem_d_addr),
        .mem_d_data_wr_i (mem_d_data_wr),
        .mem_d_wr_i      (mem_d_wr),
        .mem_d_accept_i  (mem_d_accept),
        .exp_addr_i      (exp_addr),
        .exp_data_i      (exp_data),
        .exp_count_i     (exp_count),
        .seen_count_o    (seen_count),
        .pass_count_o    (pass_count),
        .fail_count_o    (fail_count)
    );

    // Wait states before accept and ack, 0 to 2
    function automatic int pick_wait();
        return int'($urandom_range(2, 0));
    endfunction

    // Untouched data words, unique per address
    function automatic logic [31:0] fill_word(input int idx);
        return 32'hD0E0_0000 | (idx << 2);
    endfunction

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
    end

    // --------------------
    // Instruction memory
    always @(posedge clk)
    begin
        if (rst)
        begin
            i_phase      <= 0;
            i_wait       <= pick_wait();
            mem_i_accept <= 1'b0;
            mem_i_valid  <= 1'b0;
        end
        else
        begin
            mem_i_accept <= 1'b0;
            mem_i_valid  <= 1'b0;
            case (i_phase)
                0:
                begin
                    if (mem_i_rd)
                    begin
                        if (i_wait > 0)
                            i_wait <= i_wait - 1;
                        else
                        begin
                            mem_i_accept <= 1'b1;
                            fetch_pc     <= mem_i_pc;
                            i_phase      <= 1;
                        end
                    end
                end
                // Fetch taken at this edge
                1:
                begin
                    i_wait  <= pick_wait();
                    i_phase <= 2;
                end
                2:
                begin
                    if (i_wait > 0)
                        i_wait <= i_wait - 1;
                    else
                    begin
                        mem_i_valid <= 1'b1;
                        mem_i_inst  <= imem[fetch_pc[9:2]];
                        i_phase     <= 3;
                    end
                end
                default:
                begin
                    i_wait  <= pick_wait();
                    i_phase <= 0;
                end
            endcase
        end
    end

    // --------------------
    // Data memory
    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 256; i++)
                dmem[i] <= fill_word(i);
            d_phase      <= 0;
            d_wait       <= pick_wait();
            mem_d_accept <= 1'b0;
            mem_d_ack    <= 1'b0;
        end
        else
        begin
            mem_d_accept <= 1'b0;
            mem_d_ack    <= 1'b0;
            case (d_phase)
                0:
                begin
                    if (mem_d_rd || (mem_d_wr != 4'b0000))
                    begin
                        if (d_wait > 0)
                            d_wait <= d_wait - 1;
                        else
                        begin
                            mem_d_accept <= 1'b1;
                            d_idx        <= mem_d_addr[9:2];
                            d_is_wr      <= (mem_d_wr != 4'b0000);
                            d_wdata      <= mem_d_data_wr;
                            d_phase      <= 1;
                        end
                    end
                end
                // Request taken, do the access
                1:
                begin
                    if (d_is_wr)
                        dmem[d_idx] <= d_wdata;
                    d_rdata <= dmem[d_idx];
                    d_wait  <= pick_wait();
                    d_phase <= 2;
                end
                2:
                begin
                    if (d_wait > 0)
                        d_wait <= d_wait - 1;
                    else
                    begin
                        mem_d_ack     <= 1'b1;
                        mem_d_data_rd <= d_rdata;
                        d_phase       <= 3;
                    end
                end
                default:
                begin
                    d_wait  <= pick_wait();
                    d_phase <= 0;
                end
            endcase
        end
    end

    // --------------------
    // Load cases, run, report
    initial
    begin
        void'($urandom(32'hf2ce4970));
        $readmemh("verification/program_cases.txt", case_words);
        prog_len  = int'(case_words[0]);
        exp_count = int'(case_words[1]);

        // Unused words are NOPs on x0, immediate tagged with the word index
        for (int i = 0; i < 256; i++)
            imem[i] = 32'h0000_0013 | (i << 20);
        for (int i = 0; i < prog_len; i++)
            imem[i] = case_words[2 + i];
        for (int i = 0; i < 64; i++)
        begin
            exp_addr[i] = 32'h0;
            exp_data[i] = 32'h0;
        end
        for (int i = 0; i < exp_count; i++)
        begin
            exp_addr[i] = case_words[2 + prog_len + 2 * i];
            exp_data[i] = case_words[3 + prog_len + 2 * i];
        end
        cycle_limit = 40 * exp_count + 200;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        while ((seen_count < exp_count) && (cycles < cycle_limit))
            @(posedge clk);
        repeat (2) @(posedge clk);
        timed_out = (seen_count < exp_count);

        if (timed_out)
            $display("Timeout after %0d cycles with %0d of %0d stores seen",
                     cycles, seen_count, exp_count);
        $display("Stores expected %0d, passed %0d, failed %0d, assertion failures %0d",
                 exp_count, pass_count, fail_count,
                 u_uriscv_core.u_core_assert.assert_fails);
        if (!timed_out && (fail_count == 0) && (u_uriscv_core.u_core_assert.assert_fails == 0))
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verification/program_cases.txt ====
// Word 0 program length, word 1 store count, then program words from PC 0
// then one expected store per line as address followed by data
00000031 00000012
12300093 FFB00113 10000513 402081B3 00352023 0020C233 00452223 0020E2B3
0020F333 00552423 00652623 00409393 40115413 001154B3 00752823 00852A23
00952C23 001125B3 0020B633 00B52E23 02C52023 ABCDE6B7 00001717 02D52223
02E52423 00108463 02152623 00109463 02152623 00114463 02252823 00115463
02252823 0020E463 02252823 0020F463 02352A23 008007EF 02152C23 02F52C23
0AC00867 02152C23 02152C23 03052E23 02452883 05152023 08052903 05252223
0000006F
00000100 00000128
00000104 FFFFFED8
00000108 FFFFFFFB
0000010C 00000123
00000110 00001230
00000114 FFFFFFFD
00000118 1FFFFFFF
0000011C 00000001
00000120 00000001
00000124 ABCDE000
00000128 00001058
0000012C 00000123
00000130 FFFFFFFB
00000134 00000128
00000138 00000098
0000013C 000000A4
00000140 ABCDE000
00000144 D0E00180

// ==== list.f ====
src/core_pkg.sv
src/exec_if.sv
src/core_alu.sv
src/core_regfile.sv
src/core_decode.sv
src/core_sequencer.sv
src/uriscv_core.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_assert.sv
verification/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f list.f -o sim_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_top +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1
